// File: Bender.yml
package:
  name: axi_wslave

sources:
  - include_dirs:
      - source
    files:
      - source/axi_wslave_pkg.sv
      - source/wslave_req_accept.sv
      - source/tx_sync.sv
      - source/wslave_b_tx_sync.sv
      - source/axi_wslave.sv
  - target: test
    include_dirs:
      - source
    files:
      - bench/axi_wslave_chk.sv
      - bench/axi_wslave_tb.sv

// File: bench/axi_wslave_chk.sv
// sees the top level ports only; every check is off while rst is high
`timescale 1ns/1ps
`include "axi_wslave_macros.svh"
`default_nettype none

module axi_wslave_chk
  import axi_wslave_pkg::*;
(
  input logic                            hqm_gated_clk,
  input logic                            rst,
  input logic                            rst_prep,
  input logic                            core_req_valid,
  input logic                            core_req_ready,
  input logic [`AXI_WSLAVE_ADDR_W-1:0]   core_req_addr,
  input logic [`AXI_WSLAVE_DATA_W-1:0]   core_req_data,
  input logic [`AXI_WSLAVE_ID_W-1:0]     core_req_id,
  input logic [`AXI_WSLAVE_USER_W-1:0]   core_req_user,
  input logic                            core_bready,
  input logic                            bvalid,
  input logic                            bready,
  input logic [`AXI_WSLAVE_ID_W-1:0]     bid,
  input resp_e                           bresp,
  input logic [`AXI_WSLAVE_USER_W-1:0]   buser,
  input logic [`AXI_WSLAVE_STATUS_W-1:0] status
);

  // --------------------------------------------------
  // handshake stability
  // --------------------------------------------------

  // a request shown to the core holds until core_req_ready
  req_hold: assert property (@(posedge hqm_gated_clk) disable iff (rst)
    core_req_valid && !core_req_ready |=> core_req_valid &&
      $stable({core_req_addr, core_req_data, core_req_id, core_req_user}))
    else $error("core request dropped or changed before core_req_ready");

  // same rule on B
  b_hold: assert property (@(posedge hqm_gated_clk) disable iff (rst)
    bvalid && !bready |=> bvalid && $stable({bid, bresp, buser}))
    else $error("bvalid dropped or B payload changed before bready");

  // --------------------------------------------------
  // buffer state
  // --------------------------------------------------

  no_take_in_prep: assert property (@(posedge hqm_gated_clk) disable iff (rst)
    !(rst_prep && core_bready))
    else $error("core_bready high while rst_prep is set");

  // two entries deep, so occupancy 3 means a broken count
  occ_limit: assert property (@(posedge hqm_gated_clk) disable iff (rst)
    status[1:0] <= 2'd2)
    else $error("buffer occupancy above two");

endmodule

`default_nettype wire

// File: bench/axi_wslave_tb.sv
// core responses come back in order; at most 4 writes wait in the core model; stops at first error
`timescale 1ns/1ps
`include "axi_wslave_macros.svh"
`default_nettype none

module axi_wslave_tb
  import axi_wslave_pkg::*;
();

  localparam int n_writes    = 300;
  localparam int cycle_limit = n_writes * 20 + 200;
  localparam int aw_w = `AXI_WSLAVE_ADDR_W + `AXI_WSLAVE_ID_W + `AXI_WSLAVE_USER_W;

  logic                            hqm_gated_clk;
  logic                            rst;
  logic                            awvalid;
  logic                            awready;
  logic [`AXI_WSLAVE_ADDR_W-1:0]   awaddr;
  logic [`AXI_WSLAVE_ID_W-1:0]     awid;
  logic [`AXI_WSLAVE_USER_W-1:0]   awuser;
  logic                            wvalid;
  logic                            wready;
  logic [`AXI_WSLAVE_DATA_W-1:0]   wdata;
  logic                            core_req_valid;
  logic                            core_req_ready;
  logic [`AXI_WSLAVE_ADDR_W-1:0]   core_req_addr;
  logic [`AXI_WSLAVE_DATA_W-1:0]   core_req_data;
  logic [`AXI_WSLAVE_ID_W-1:0]     core_req_id;
  logic [`AXI_WSLAVE_USER_W-1:0]   core_req_user;
  logic                            core_bvalid;
  logic                            core_bready;
  logic [`AXI_WSLAVE_ID_W-1:0]     core_bid;
  resp_e                           core_bresp;
  logic [`AXI_WSLAVE_USER_W-1:0]   core_buser;
  logic                            bvalid;
  logic                            bready;
  logic [`AXI_WSLAVE_ID_W-1:0]     bid;
  resp_e                           bresp;
  logic [`AXI_WSLAVE_USER_W-1:0]   buser;
  logic                            rst_prep;
  logic                            idle;
  logic [`AXI_WSLAVE_STATUS_W-1:0] status;

  logic [31:0]                   rng;
  int                            cycle_cnt;
  int                            b_cnt;
  // reference queues hold AW entries packed as addr, id, user
  logic [aw_w-1:0]               exp_aw[$];
  logic [`AXI_WSLAVE_DATA_W-1:0] exp_w[$];
  // B entries use the same id, code, user layout as the bus fields
  logic [`AXI_WSLAVE_B_W-1:0]    exp_b[$];
  // ids of requests the core model has taken and not yet answered
  logic [`AXI_WSLAVE_ID_W-1:0]   core_ids[$];
  logic [aw_w-1:0]               aw_ent;
  logic [`AXI_WSLAVE_B_W-1:0]    b_ent;

  axi_wslave dut_i (.*);

  bind axi_wslave axi_wslave_chk chk_i (.*);

  initial begin
    hqm_gated_clk = 1'b0;
    forever #4 hqm_gated_clk = ~hqm_gated_clk;
  end

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------

  function automatic logic [31:0] next_random();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  task automatic stop_run();
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic compare_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
      stop_run();
    end
  endtask

  // all drive tasks start and end 1 ns after a rising edge
  task automatic drive_aw();
    logic [31:0] r;
    r = next_random();
    awvalid = 1'b1;
    awaddr  = next_random();
    awid    = r[`AXI_WSLAVE_ID_W-1:0];
    awuser  = r[8 +: `AXI_WSLAVE_USER_W];
    exp_aw.push_back({awaddr, awid, awuser});
  endtask

  task automatic drive_w();
    wvalid = 1'b1;
    wdata  = next_random();
    exp_w.push_back(wdata);
  endtask

  task automatic present_response(input logic [`AXI_WSLAVE_ID_W-1:0] id);
    logic [31:0] r;
    r = next_random();
    core_bvalid = 1'b1;
    core_bid    = id;
    core_bresp  = resp_e'(r[1:0]);
    core_buser  = r[8 +: `AXI_WSLAVE_USER_W];
  endtask

  task automatic wait_core_taken();
    logic taken;
    taken = 1'b0;
    while (!taken) begin
      @(negedge hqm_gated_clk);
      taken = core_bvalid && core_bready;
      @(posedge hqm_gated_clk);
      #1;
    end
    core_bvalid = 1'b0;
  endtask

  task automatic answer_core(input logic [`AXI_WSLAVE_ID_W-1:0] id);
    present_response(id);
    wait_core_taken();
  endtask

  task automatic wait_idle();
    logic seen;
    seen = 1'b0;
    while (!seen) begin
      @(negedge hqm_gated_clk);
      seen = idle;
      @(posedge hqm_gated_clk);
      #1;
    end
  endtask

  // one write with AW and W together, returns once the core has taken it
  task automatic send_write();
    logic fire_aw;
    logic fire_w;
    logic req_seen;
    drive_aw();
    drive_w();
    core_req_ready = 1'b1;
    req_seen = 1'b0;
    while (!req_seen) begin
      @(negedge hqm_gated_clk);
      req_seen = core_req_valid && core_req_ready;
      fire_aw  = awvalid && awready;
      fire_w   = wvalid && wready;
      @(posedge hqm_gated_clk);
      #1;
      if (fire_aw) awvalid = 1'b0;
      if (fire_w) wvalid = 1'b0;
    end
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    repeat (3) @(posedge hqm_gated_clk);
    #1;
    rst = 1'b0;
  endtask

  task automatic check_reset_state();
    @(negedge hqm_gated_clk);
    compare_value("bvalid", bvalid, 1'b0);
    compare_value("core_req_valid", core_req_valid, 1'b0);
    compare_value("idle", idle, 1'b1);
    compare_value("awready", awready, 1'b1);
    compare_value("wready", wready, 1'b1);
    compare_value("status", status, 32'd0);
    @(posedge hqm_gated_clk);
    #1;
  endtask

  // random valid gaps on AW and W, random core delay, core_req_ready and bready
  task automatic run_random(input int n);
    int          aw_left;
    int          w_left;
    int          b_goal;
    logic        fire_aw;
    logic        fire_w;
    logic        fire_cb;
    logic [31:0] r;
    aw_left = n;
    w_left  = n;
    b_goal  = b_cnt + n;
    while (b_cnt < b_goal) begin
      @(negedge hqm_gated_clk);
      fire_aw = awvalid && awready;
      fire_w  = wvalid && wready;
      fire_cb = core_bvalid && core_bready;
      @(posedge hqm_gated_clk);
      #1;
      r = next_random();
      if (fire_aw) awvalid = 1'b0;
      if (fire_w) wvalid = 1'b0;
      if (fire_cb) core_bvalid = 1'b0;
      if (!awvalid && aw_left > 0 && r[0]) begin
        drive_aw();
        aw_left--;
      end
      if (!wvalid && w_left > 0 && r[1]) begin
        drive_w();
        w_left--;
      end
      if (!core_bvalid && core_ids.size() > 0 && r[2]) present_response(core_ids.pop_front());
      // the core stops taking requests while its queue is long, which keeps
      // the outstanding count well below the counter wrap
      core_req_ready = r[3] && (core_ids.size() < 3);
      bready = (r[5:4] != 2'b00);
    end
    core_req_ready = 1'b0;
    bready = 1'b1;
  endtask

  // --------------------------------------------------
  // monitors
  // --------------------------------------------------

  // every core request must be the next AW paired with the next W
  always @(negedge hqm_gated_clk) begin
    if (!rst && core_req_valid && core_req_ready) begin
      if (exp_aw.size() == 0 || exp_w.size() == 0) begin
        $display("a core request was issued with no AW/W pair left to match it");
        stop_run();
      end else begin
        aw_ent = exp_aw.pop_front();
        compare_value("core_req_addr", core_req_addr, aw_ent[aw_w-1 -: `AXI_WSLAVE_ADDR_W]);
        compare_value("core_req_id", core_req_id, aw_ent[`AXI_WSLAVE_USER_W +: `AXI_WSLAVE_ID_W]);
        compare_value("core_req_user", core_req_user, aw_ent[`AXI_WSLAVE_USER_W-1:0]);
        compare_value("core_req_data", core_req_data, exp_w.pop_front());
        core_ids.push_back(core_req_id);
      end
    end
  end

  // B must replay accepted core responses in order, one for one
  always @(negedge hqm_gated_clk) begin
    if (!rst && bvalid && bready) begin
      if (exp_b.size() == 0) begin
        $display("a B transfer appeared with no core response to match it");
        stop_run();
      end else begin
        b_ent = exp_b.pop_front();
        compare_value("bid", bid, b_ent[`AXI_WSLAVE_B_W-1 -: `AXI_WSLAVE_ID_W]);
        compare_value("bresp", bresp, b_ent[`AXI_WSLAVE_USER_W +: 2]);
        compare_value("buser", buser, b_ent[`AXI_WSLAVE_USER_W-1:0]);
        b_cnt++;
      end
    end
    if (!rst && core_bvalid && core_bready) exp_b.push_back({core_bid, core_bresp, core_buser});
  end

  always @(posedge hqm_gated_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      stop_run();
    end
  end

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------

  initial begin
    int          b_mark;
    logic [31:0] stray;
    rng = 32'd55082;
    cycle_cnt = 0;
    b_cnt = 0;
    rst = 1'b1;
    awvalid = 1'b0;
    awaddr = '0;
    awid = '0;
    awuser = '0;
    wvalid = 1'b0;
    wdata = '0;
    core_req_ready = 1'b0;
    core_bvalid = 1'b0;
    core_bid = '0;
    core_bresp = resp_okay;
    core_buser = '0;
    bready = 1'b1;
    rst_prep = 1'b0;
    apply_reset();
    check_reset_state();

    run_random(n_writes);
    wait_idle();
    compare_value("status[4] after random traffic", status[4], 1'b0);

    // under back-pressure the third response must wait for room in the buffer
    bready = 1'b0;
    repeat (3) send_write();
    answer_core(core_ids.pop_front());
    answer_core(core_ids.pop_front());
    present_response(core_ids.pop_front());
    @(negedge hqm_gated_clk);
    compare_value("core_bready", core_bready, 1'b0);
    compare_value("status[3:0]", status[3:0], 4'b0110);
    // three writes issued and none of them has left on B yet
    compare_value("status[6:5]", status[6:5], 2'd3);
    @(posedge hqm_gated_clk);
    #1;
    bready = 1'b1;
    wait_core_taken();
    wait_idle();

    // reset prepare blocks the core side but still lets the buffer drain
    bready = 1'b0;
    repeat (3) send_write();
    answer_core(core_ids.pop_front());
    answer_core(core_ids.pop_front());
    rst_prep = 1'b1;
    present_response(core_ids.pop_front());
    bready = 1'b1;
    b_mark = b_cnt;
    repeat (4) begin
      @(negedge hqm_gated_clk);
      compare_value("core_bready", core_bready, 1'b0);
      compare_value("status[3]", status[3], 1'b1);
      @(posedge hqm_gated_clk);
      #1;
    end
    compare_value("B transfers under rst_prep", b_cnt - b_mark, 2);
    compare_value("idle", idle, 1'b0);
    // only the write still held back by the core is outstanding
    compare_value("status[6:5] under rst_prep", status[6:5], 2'd1);
    rst_prep = 1'b0;
    wait_core_taken();
    wait_idle();

    // a response with nothing outstanding is flagged and still forwarded
    stray = next_random();
    present_response(stray[`AXI_WSLAVE_ID_W-1:0]);
    wait_core_taken();
    wait_idle();
    compare_value("status[4]", status[4], 1'b1);
    send_write();
    answer_core(core_ids.pop_front());
    wait_idle();
    compare_value("status[4] sticky", status[4], 1'b1);

    apply_reset();
    check_reset_state();
    compare_value("AW entries left", exp_aw.size(), 0);
    compare_value("W entries left", exp_w.size(), 0);
    compare_value("B entries left", exp_b.size(), 0);
    compare_value("core ids left", core_ids.size(), 0);
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: source/axi_wslave.sv
// single-beat write slave top; the core is external and answers writes in order through core_b*
`timescale 1ns/1ps
`include "axi_wslave_macros.svh"
`default_nettype none

module axi_wslave
  import axi_wslave_pkg::*;
(
  input  logic                            hqm_gated_clk,
  input  logic                            rst,
  // AW and W channels
  input  logic                            awvalid,
  output logic                            awready,
  input  logic [`AXI_WSLAVE_ADDR_W-1:0]   awaddr,
  input  logic [`AXI_WSLAVE_ID_W-1:0]     awid,
  input  logic [`AXI_WSLAVE_USER_W-1:0]   awuser,
  input  logic                            wvalid,
  output logic                            wready,
  input  logic [`AXI_WSLAVE_DATA_W-1:0]   wdata,
  // core request
  output logic                            core_req_valid,
  input  logic                            core_req_ready,
  output logic [`AXI_WSLAVE_ADDR_W-1:0]   core_req_addr,
  output logic [`AXI_WSLAVE_DATA_W-1:0]   core_req_data,
  output logic [`AXI_WSLAVE_ID_W-1:0]     core_req_id,
  output logic [`AXI_WSLAVE_USER_W-1:0]   core_req_user,
  // core response
  input  logic                            core_bvalid,
  output logic                            core_bready,
  input  logic [`AXI_WSLAVE_ID_W-1:0]     core_bid,
  input  resp_e                           core_bresp,
  input  logic [`AXI_WSLAVE_USER_W-1:0]   core_buser,
  // B channel
  output logic                            bvalid,
  input  logic                            bready,
  output logic [`AXI_WSLAVE_ID_W-1:0]     bid,
  output resp_e                           bresp,
  output logic [`AXI_WSLAVE_USER_W-1:0]   buser,
  // control
  input  logic                            rst_prep,
  output logic                            idle,
  output logic [`AXI_WSLAVE_STATUS_W-1:0] status
);

  logic req_issued;

  // --------------------------------------------------
  // request side
  // --------------------------------------------------

  wslave_req_accept req_accept_i (
    .hqm_gated_clk  (hqm_gated_clk),
    .rst            (rst),
    .awvalid        (awvalid),
    .awready        (awready),
    .awaddr         (awaddr),
    .awid           (awid),
    .awuser         (awuser),
    .wvalid         (wvalid),
    .wready         (wready),
    .wdata          (wdata),
    .core_req_valid (core_req_valid),
    .core_req_ready (core_req_ready),
    .core_req_addr  (core_req_addr),
    .core_req_data  (core_req_data),
    .core_req_id    (core_req_id),
    .core_req_user  (core_req_user)
  );

  // a request handed to the core is one more write waiting for its response
  assign req_issued = core_req_valid && core_req_ready;

  // --------------------------------------------------
  // response side
  // --------------------------------------------------

  wslave_b_tx_sync b_tx_sync_i (
    .hqm_gated_clk (hqm_gated_clk),
    .rst           (rst),
    .rst_prep      (rst_prep),
    .req_issued    (req_issued),
    .core_bvalid   (core_bvalid),
    .core_bready   (core_bready),
    .core_bid      (core_bid),
    .core_bresp    (core_bresp),
    .core_buser    (core_buser),
    .bvalid        (bvalid),
    .bready        (bready),
    .bid           (bid),
    .bresp         (bresp),
    .buser         (buser),
    .idle          (idle),
    .status        (status)
  );

endmodule

`default_nettype wire

// File: source/axi_wslave_macros.svh
// widths only; every module takes its sizes from here, so changing one value resizes the whole design
`ifndef AXI_WSLAVE_MACROS_SVH
`define AXI_WSLAVE_MACROS_SVH

// --------------------------------------------------
// bus field widths
// --------------------------------------------------

// transaction id carried on AW and returned on B
`define AXI_WSLAVE_ID_W 6

// user bits, shared by the AW side and the B side
`define AXI_WSLAVE_USER_W 6

// single-beat write address and data
`define AXI_WSLAVE_ADDR_W 32
`define AXI_WSLAVE_DATA_W 32

// --------------------------------------------------
// response path widths
// --------------------------------------------------

// packed B entry is id, two-bit response code and user, 14 bits
`define AXI_WSLAVE_B_W (`AXI_WSLAVE_ID_W + 2 + `AXI_WSLAVE_USER_W)

// outstanding counter wraps above 7 writes in flight
`define AXI_WSLAVE_OUTS_W 3
`define AXI_WSLAVE_STATUS_W 7

`endif

// File: source/axi_wslave_pkg.sv
// types shared by the write slave and its testbench; the response code follows the AXI encoding
`default_nettype none

package axi_wslave_pkg;

  // --------------------------------------------------
  // B channel response code
  // --------------------------------------------------

  // values match the bresp encoding of the bus
  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_exokay = 2'b01,
    resp_slverr = 2'b10,
    resp_decerr = 2'b11
  } resp_e;

  // --------------------------------------------------
  // producer FSM
  // --------------------------------------------------

  // collect waits for both AW and W to be held
  // issue presents the joined request to the core
  typedef enum logic {
    req_collect = 1'b0,
    req_issue   = 1'b1
  } req_state_e;

endpackage

`default_nettype wire

// File: source/tx_sync.sv
// two-entry buffer of fixed B entry width; rst_prep blocks new entries but never the drain
`timescale 1ns/1ps
`include "axi_wslave_macros.svh"
`default_nettype none

module tx_sync (
  input  logic                       hqm_gated_clk,
  input  logic                       rst,
  input  logic                       rst_prep,
  // write side
  input  logic                       in_valid,
  output logic                       in_ready,
  input  logic [`AXI_WSLAVE_B_W-1:0] in_data,
  // read side
  output logic                       out_valid,
  input  logic                       out_ready,
  output logic [`AXI_WSLAVE_B_W-1:0] out_data,
  // observation
  output logic                       idle,
  output logic [3:0]                 status
);

  logic [`AXI_WSLAVE_B_W-1:0] mem [2];
  logic                       wr_ptr;
  logic                       rd_ptr;
  logic [1:0]                 count;
  logic                       full;
  logic                       push;
  logic                       pop;

  // --------------------------------------------------
  // handshakes
  // --------------------------------------------------

  assign full = (count == 2'd2);

  // while a reset is being prepared nothing new may enter
  assign in_ready = !full && !rst_prep;
  assign push     = in_valid && in_ready;

  // valid comes straight from the registered count, so an entry written
  // on an edge is visible on the next cycle
  assign out_valid = (count != 2'd0);
  assign pop       = out_valid && out_ready;
  assign out_data  = mem[rd_ptr];

  // --------------------------------------------------
  // pointers and occupancy
  // --------------------------------------------------

  always_ff @(posedge hqm_gated_clk) begin
    if (rst) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (push) wr_ptr <= !wr_ptr;
      if (pop) rd_ptr <= !rd_ptr;
      // a push and a pop on the same edge leave the count as it is
      case ({push, pop})
        2'b10:   count <= count + 2'd1;
        2'b01:   count <= count - 2'd1;
        default: count <= count;
      endcase
    end
  end

  // storage, written at the write pointer only
  always_ff @(posedge hqm_gated_clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // --------------------------------------------------
  // observation
  // --------------------------------------------------

  assign idle = (count == 2'd0);

  // bit 3 blocked by rst_prep, bit 2 full, bits 1:0 occupancy
  assign status = {rst_prep, full, count};

endmodule

`default_nettype wire

// File: source/wslave_b_tx_sync.sv
// counts at most 7 writes in flight; an unexpected response is flagged and still forwarded
`timescale 1ns/1ps
`include "axi_wslave_macros.svh"
`default_nettype none

module wslave_b_tx_sync
  import axi_wslave_pkg::*;
(
  input  logic                            hqm_gated_clk,
  input  logic                            rst,
  input  logic                            rst_prep,
  input  logic                            req_issued,
  // response from the core
  input  logic                            core_bvalid,
  output logic                            core_bready,
  input  logic [`AXI_WSLAVE_ID_W-1:0]     core_bid,
  input  resp_e                           core_bresp,
  input  logic [`AXI_WSLAVE_USER_W-1:0]   core_buser,
  // B channel
  output logic                            bvalid,
  input  logic                            bready,
  output logic [`AXI_WSLAVE_ID_W-1:0]     bid,
  output resp_e                           bresp,
  output logic [`AXI_WSLAVE_USER_W-1:0]   buser,
  output logic                            idle,
  output logic [`AXI_WSLAVE_STATUS_W-1:0] status
);

  logic [`AXI_WSLAVE_B_W-1:0]    buf_in_data;
  logic [`AXI_WSLAVE_B_W-1:0]    buf_out_data;
  logic                          buf_idle;
  logic [3:0]                    buf_status;
  logic                          core_push;
  logic                          b_pop;
  logic                          unexp;
  logic                          unexp_flag;
  logic [`AXI_WSLAVE_OUTS_W-1:0] pend_cnt;
  logic [`AXI_WSLAVE_OUTS_W-1:0] outs_cnt;

  // --------------------------------------------------
  // buffer and packing
  // --------------------------------------------------

  // the entry is laid out as id, then code, then user
  assign buf_in_data = {core_bid, core_bresp, core_buser};

  tx_sync b_sync_i (
    .hqm_gated_clk (hqm_gated_clk),
    .rst           (rst),
    .rst_prep      (rst_prep),
    .in_valid      (core_bvalid),
    .in_ready      (core_bready),
    .in_data       (buf_in_data),
    .out_valid     (bvalid),
    .out_ready     (bready),
    .out_data      (buf_out_data),
    .idle          (buf_idle),
    .status        (buf_status)
  );

  assign bid   = buf_out_data[`AXI_WSLAVE_B_W-1 -: `AXI_WSLAVE_ID_W];
  assign bresp = resp_e'(buf_out_data[`AXI_WSLAVE_USER_W +: 2]);
  assign buser = buf_out_data[`AXI_WSLAVE_USER_W-1:0];

  // --------------------------------------------------
  // outstanding tracking
  // --------------------------------------------------

  assign core_push = core_bvalid && core_bready;
  assign b_pop     = bvalid && bready;

  // pend_cnt holds writes issued but not yet answered by the core
  assign unexp = core_push && (pend_cnt == '0);

  always_ff @(posedge hqm_gated_clk) begin
    if (rst) begin
      pend_cnt   <= '0;
      outs_cnt   <= '0;
      unexp_flag <= 1'b0;
    end else begin
      // a response with nothing pending leaves pend_cnt at zero
      pend_cnt <= pend_cnt + {2'b00, req_issued} - {2'b00, core_push && !unexp};
      // an unexpected entry is counted too, since it still leaves on B
      outs_cnt <= outs_cnt + {2'b00, req_issued} + {2'b00, unexp} - {2'b00, b_pop};
      // sticky until the next reset
      if (unexp) unexp_flag <= 1'b1;
    end
  end

  assign idle   = buf_idle && (outs_cnt == '0);
  assign status = {outs_cnt[1:0], unexp_flag, buf_status};

endmodule

`default_nettype wire

// File: source/wslave_req_accept.sv
// single-beat writes only; no strobes, no wlast, at most one request every two cycles
`timescale 1ns/1ps
`include "axi_wslave_macros.svh"
`default_nettype none

module wslave_req_accept
  import axi_wslave_pkg::*;
(
  input  logic                          hqm_gated_clk,
  input  logic                          rst,
  // AW channel
  input  logic                          awvalid,
  output logic                          awready,
  input  logic [`AXI_WSLAVE_ADDR_W-1:0] awaddr,
  input  logic [`AXI_WSLAVE_ID_W-1:0]   awid,
  input  logic [`AXI_WSLAVE_USER_W-1:0] awuser,
  // W channel
  input  logic                          wvalid,
  output logic                          wready,
  input  logic [`AXI_WSLAVE_DATA_W-1:0] wdata,
  // joined request towards the core
  output logic                          core_req_valid,
  input  logic                          core_req_ready,
  output logic [`AXI_WSLAVE_ADDR_W-1:0] core_req_addr,
  output logic [`AXI_WSLAVE_DATA_W-1:0] core_req_data,
  output logic [`AXI_WSLAVE_ID_W-1:0]   core_req_id,
  output logic [`AXI_WSLAVE_USER_W-1:0] core_req_user
);

  req_state_e                    state;
  req_state_e                    state_nxt;
  logic                          aw_full;
  logic                          w_full;
  logic                          aw_take;
  logic                          w_take;
  logic                          req_done;
  logic [`AXI_WSLAVE_ADDR_W-1:0] addr_q;
  logic [`AXI_WSLAVE_DATA_W-1:0] data_q;
  logic [`AXI_WSLAVE_ID_W-1:0]   id_q;
  logic [`AXI_WSLAVE_USER_W-1:0] user_q;

  // each channel is open while its own hold register is empty
  assign awready = !aw_full;
  assign wready  = !w_full;
  assign aw_take = awvalid && awready;
  assign w_take  = wvalid && wready;

  assign core_req_valid = (state == req_issue);
  assign req_done       = core_req_valid && core_req_ready;

  // --------------------------------------------------
  // FSM
  // --------------------------------------------------

  // the move to issue happens on the edge of the later capture, so that
  // core_req_valid is up on the very next cycle
  always_comb begin
    state_nxt = state;
    case (state)
      req_collect: begin
        if ((aw_full || aw_take) && (w_full || w_take)) begin
          state_nxt = req_issue;
        end
      end
      req_issue: begin
        if (core_req_ready) begin
          state_nxt = req_collect;
        end
      end
      default: state_nxt = req_collect;
    endcase
  end

  // full flags are set by a capture and both drop together on acceptance
  always_ff @(posedge hqm_gated_clk) begin
    if (rst) begin
      state   <= req_collect;
      aw_full <= 1'b0;
      w_full  <= 1'b0;
    end else begin
      state <= state_nxt;
      if (req_done) begin
        aw_full <= 1'b0;
        w_full  <= 1'b0;
      end else begin
        if (aw_take) aw_full <= 1'b1;
        if (w_take) w_full <= 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // hold registers
  // --------------------------------------------------

  // payload only, qualified by the full flags above
  always_ff @(posedge hqm_gated_clk) begin
    if (aw_take) begin
      addr_q <= awaddr;
      id_q   <= awid;
      user_q <= awuser;
    end
    if (w_take) begin
      data_q <= wdata;
    end
  end

  assign core_req_addr = addr_q;
  assign core_req_data = data_q;
  assign core_req_id   = id_q;
  assign core_req_user = user_q;

endmodule

`default_nettype wire

// File: verilog.f
+incdir+source
source/axi_wslave_pkg.sv
source/wslave_req_accept.sv
source/tx_sync.sv
source/wslave_b_tx_sync.sv
source/axi_wslave.sv
bench/axi_wslave_chk.sv
bench/axi_wslave_tb.sv
